//--- logic/cp_remover.sv
`timescale 1ns/1ps

module cp_remover #(
  parameter int fft_len = ofdm_frame_pkg::FFT_LEN_DEF,
  parameter int cp_len  = ofdm_frame_pkg::CP_LEN_DEF,
  parameter int n_sym   = ofdm_frame_pkg::N_SYM_DEF,
  localparam int burst_len = n_sym * (fft_len + cp_len),
  localparam int addr_w    = $clog2(2 * burst_len),
  localparam int ptr_w     = $clog2(fft_len * n_sym)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    copy_start,
  input  logic [addr_w-1:0]       peak_index,
  input  ofdm_frame_pkg::sample_t sample,
  output logic [addr_w-1:0]       copy_addr,
  output logic                    out_we,
  output logic [ptr_w-1:0]        out_addr,
  output ofdm_frame_pkg::sample_t out_data,
  output logic                    copy_done
);

  localparam int sym_len = fft_len + cp_len;  // body plus its prefix
  localparam int s_w     = $clog2(n_sym + 1);
  localparam int k_w     = $clog2(fft_len);

  logic           active;
  logic [s_w-1:0] sym;
  logic [k_w-1:0] k;
  logic           last_rd;
  logic           last_q;

  assign last_rd = active && (sym == s_w'(n_sym - 1)) && (k == k_w'(fft_len - 1));

  // peak + s*(fft_len+cp_len) + k, peak_index is settled before active rises
  assign copy_addr = addr_w'(peak_index + sym * sym_len + k);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      sym    <= '0;
      k      <= '0;
    end else if (copy_start) begin
      active <= 1'b1;
      sym    <= '0;
      k      <= '0;
    end else if (active) begin
      if (k == k_w'(fft_len - 1)) begin
        k   <= '0;
        sym <= sym + 1'b1;
        if (sym == s_w'(n_sym - 1)) begin
          active <= 1'b0;  // all bodies read
        end
      end else begin
        k <= k + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // write side, one cycle behind the read
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    out_addr <= ptr_w'(sym * fft_len + k);
  end

  assign out_data = sample;  // read data lands with out_addr

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_we    <= 1'b0;
      last_q    <= 1'b0;
      copy_done <= 1'b0;
    end else begin
      out_we    <= active;
      last_q    <= last_rd;
      copy_done <= last_q;  // one cycle after the final write
    end
  end

endmodule

//--- logic/ofdm_frame_pkg.sv
package ofdm_frame_pkg;

  ////////////////////////////////////////
  // sample and sum types
  ////////////////////////////////////////

  typedef logic signed [7:0]  sample_t;  // one received real sample
  typedef logic signed [23:0] corr_t;    // delay-and-correlate sum P
  typedef logic        [23:0] energy_t;  // window energy R, never negative

  ////////////////////////////////////////
  // default frame geometry
  ////////////////////////////////////////

  // burst_len = n_sym * (fft_len + cp_len), capture holds two bursts
  localparam int FFT_LEN_DEF = 16;
  localparam int CP_LEN_DEF  = 4;
  localparam int N_SYM_DEF   = 3;

endpackage

//--- logic/ofdm_time_sync.sv
`timescale 1ns/1ps

module ofdm_time_sync #(
  parameter int fft_len = ofdm_frame_pkg::FFT_LEN_DEF,
  parameter int cp_len  = ofdm_frame_pkg::CP_LEN_DEF,
  parameter int n_sym   = ofdm_frame_pkg::N_SYM_DEF,
  localparam int burst_len = n_sym * (fft_len + cp_len),
  localparam int addr_w    = $clog2(2 * burst_len),
  localparam int ptr_w     = $clog2(fft_len * n_sym)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    restart,
  input  ofdm_frame_pkg::sample_t din,
  input  logic                    wren,
  input  logic [ptr_w-1:0]        read_ptr,
  output ofdm_frame_pkg::sample_t dout,
  output logic                    busy,
  output logic                    ready,
  output logic [addr_w-1:0]       peak_index
);

  logic                    wr_en;
  logic [addr_w-1:0]       wr_addr;
  ofdm_frame_pkg::sample_t wr_data;
  logic [addr_w-1:0]       rd_addr_a;
  logic [addr_w-1:0]       rd_addr_b;
  ofdm_frame_pkg::sample_t rd_data_a;
  ofdm_frame_pkg::sample_t rd_data_b;
  logic                    pair_valid;
  logic                    pair_first;
  logic                    pair_last;
  logic                    clear;
  logic                    copy_start;
  logic [addr_w-1:0]       copy_addr;
  logic                    copy_done;
  ofdm_frame_pkg::corr_t   p;
  ofdm_frame_pkg::energy_t r;
  logic                    metric_valid;
  logic                    out_we;
  logic [ptr_w-1:0]        out_addr;
  ofdm_frame_pkg::sample_t out_data;

  ////////////////////////////////////////
  // control and capture
  ////////////////////////////////////////

  sync_ctrl #(.fft_len(fft_len), .cp_len(cp_len), .n_sym(n_sym)) u_ctrl (
    .clk(clk), .rst_n(rst_n), .restart(restart), .din(din), .wren(wren),
    .copy_addr(copy_addr), .copy_done(copy_done),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .pair_valid(pair_valid), .pair_first(pair_first), .pair_last(pair_last),
    .clear(clear), .copy_start(copy_start), .busy(busy), .ready(ready)
  );

  sample_buffer #(.fft_len(fft_len), .cp_len(cp_len), .n_sym(n_sym)) u_samples (
    .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
  );

  ////////////////////////////////////////
  // metric, peak search, cp removal
  ////////////////////////////////////////

  timing_metric u_metric (
    .clk(clk), .rst_n(rst_n), .sample_a(rd_data_a), .sample_b(rd_data_b),
    .pair_valid(pair_valid), .pair_first(pair_first), .pair_last(pair_last),
    .p(p), .r(r), .metric_valid(metric_valid)
  );

  peak_detector #(.fft_len(fft_len), .cp_len(cp_len), .n_sym(n_sym)) u_peak (
    .clk(clk), .rst_n(rst_n), .clear(clear), .p(p), .r(r),
    .metric_valid(metric_valid), .peak_index(peak_index)
  );

  cp_remover #(.fft_len(fft_len), .cp_len(cp_len), .n_sym(n_sym)) u_cp (
    .clk(clk), .rst_n(rst_n), .copy_start(copy_start), .peak_index(peak_index),
    .sample(rd_data_a), .copy_addr(copy_addr), .out_we(out_we),
    .out_addr(out_addr), .out_data(out_data), .copy_done(copy_done)
  );

  symbol_buffer #(.fft_len(fft_len), .n_sym(n_sym)) u_symbols (
    .clk(clk), .we(out_we), .wr_addr(out_addr), .wr_data(out_data),
    .read_ptr(read_ptr), .dout(dout)
  );

endmodule

//--- logic/peak_detector.sv
`timescale 1ns/1ps

module peak_detector #(
  parameter int fft_len = ofdm_frame_pkg::FFT_LEN_DEF,
  parameter int cp_len  = ofdm_frame_pkg::CP_LEN_DEF,
  parameter int n_sym   = ofdm_frame_pkg::N_SYM_DEF,
  localparam int burst_len = n_sym * (fft_len + cp_len),
  localparam int addr_w    = $clog2(2 * burst_len)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clear,
  input  ofdm_frame_pkg::corr_t   p,
  input  ofdm_frame_pkg::energy_t r,
  input  logic                    metric_valid,
  output logic [addr_w-1:0]       peak_index
);

  localparam int cw = $bits(ofdm_frame_pkg::corr_t);

  ofdm_frame_pkg::corr_t   best_p;
  ofdm_frame_pkg::energy_t best_r;
  logic [addr_w-1:0]       cand_cnt;  // index of the candidate on p and r
  logic [cw-1:0]           p_abs;
  logic [cw-1:0]           best_abs;
  logic [2*cw-1:0]         p_sq;
  logic [2*cw-1:0]         best_p_sq;
  logic [2*cw-1:0]         r_sq;
  logic [2*cw-1:0]         best_r_sq;
  logic [4*cw-1:0]         lhs;
  logic [4*cw-1:0]         rhs;
  logic                    win;

  assign p_abs    = p[cw-1] ? cw'(-p) : cw'(p);
  assign best_abs = best_p[cw-1] ? cw'(-best_p) : cw'(best_p);

  assign p_sq      = p_abs * p_abs;
  assign best_p_sq = best_abs * best_abs;
  assign r_sq      = r * r;
  assign best_r_sq = best_r * best_r;

  // P^2/R^2 > Pbest^2/Rbest^2 without a divider
  assign lhs = p_sq * best_r_sq;
  assign rhs = best_p_sq * r_sq;
  assign win = metric_valid && (r != '0) && (lhs > rhs);  // strict, first peak kept

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cand_cnt   <= '0;
      best_p     <= '0;
      best_r     <= ofdm_frame_pkg::energy_t'(1);
      peak_index <= '0;
    end else if (clear) begin
      cand_cnt   <= '0;
      best_p     <= '0;
      best_r     <= ofdm_frame_pkg::energy_t'(1);  // so any nonzero P wins first
      peak_index <= '0;
    end else if (metric_valid) begin
      cand_cnt <= cand_cnt + 1'b1;
      if (win) begin
        best_p     <= p;
        best_r     <= r;
        peak_index <= cand_cnt;
      end
    end
  end

endmodule

//--- logic/sample_buffer.sv
`timescale 1ns/1ps

module sample_buffer #(
  parameter int fft_len = ofdm_frame_pkg::FFT_LEN_DEF,
  parameter int cp_len  = ofdm_frame_pkg::CP_LEN_DEF,
  parameter int n_sym   = ofdm_frame_pkg::N_SYM_DEF,
  localparam int burst_len = n_sym * (fft_len + cp_len),
  localparam int depth     = 2 * burst_len,
  localparam int addr_w    = $clog2(depth)
) (
  input  logic                    clk,
  input  logic                    wr_en,
  input  logic [addr_w-1:0]       wr_addr,
  input  ofdm_frame_pkg::sample_t wr_data,
  input  logic [addr_w-1:0]       rd_addr_a,
  input  logic [addr_w-1:0]       rd_addr_b,
  output ofdm_frame_pkg::sample_t rd_data_a,
  output ofdm_frame_pkg::sample_t rd_data_b
);

  ofdm_frame_pkg::sample_t mem [depth];  // two bursts of capture

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // both ports read every cycle, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data_a <= mem[rd_addr_a];  // d+k in METRIC, cp remover in COPY
    rd_data_b <= mem[rd_addr_b];  // d+k+L
  end

endmodule

//--- logic/symbol_buffer.sv
`timescale 1ns/1ps

module symbol_buffer #(
  parameter int fft_len = ofdm_frame_pkg::FFT_LEN_DEF,
  parameter int n_sym   = ofdm_frame_pkg::N_SYM_DEF,
  localparam int depth  = fft_len * n_sym,
  localparam int ptr_w  = $clog2(depth)
) (
  input  logic                    clk,
  input  logic                    we,
  input  logic [ptr_w-1:0]        wr_addr,
  input  ofdm_frame_pkg::sample_t wr_data,
  input  logic [ptr_w-1:0]        read_ptr,
  output ofdm_frame_pkg::sample_t dout
);

  ofdm_frame_pkg::sample_t mem [depth];  // symbol bodies, prefixes removed

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    dout <= mem[read_ptr];  // registered read-out
  end

endmodule

//--- logic/sync_ctrl.sv
`timescale 1ns/1ps

module sync_ctrl #(
  parameter int fft_len = ofdm_frame_pkg::FFT_LEN_DEF,
  parameter int cp_len  = ofdm_frame_pkg::CP_LEN_DEF,
  parameter int n_sym   = ofdm_frame_pkg::N_SYM_DEF,
  localparam int burst_len = n_sym * (fft_len + cp_len),
  localparam int addr_w    = $clog2(2 * burst_len)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    restart,
  input  ofdm_frame_pkg::sample_t din,
  input  logic                    wren,
  input  logic [addr_w-1:0]       copy_addr,
  input  logic                    copy_done,
  output logic                    wr_en,
  output logic [addr_w-1:0]       wr_addr,
  output ofdm_frame_pkg::sample_t wr_data,
  output logic [addr_w-1:0]       rd_addr_a,
  output logic [addr_w-1:0]       rd_addr_b,
  output logic                    pair_valid,
  output logic                    pair_first,
  output logic                    pair_last,
  output logic                    clear,
  output logic                    copy_start,
  output logic                    busy,
  output logic                    ready
);

  localparam int half_len = fft_len / 2;  // L
  localparam int k_w      = $clog2(fft_len);

  sync_state_pkg::phase_e phase;
  logic [addr_w-1:0]      cap_cnt;
  logic [addr_w-1:0]      cand;      // candidate d
  logic [k_w-1:0]         k;         // offset inside the window
  logic                   drain_cnt;
  logic                   cap_last;
  logic                   win_last;
  logic                   cand_last;
  logic                   in_metric;

  // capture goes straight to the buffer, extra samples are dropped
  assign wr_en   = wren && (phase == sync_state_pkg::CAPTURE);
  assign wr_addr = cap_cnt;
  assign wr_data = din;

  assign cap_last  = wr_en && (cap_cnt == addr_w'(2 * burst_len - 1));
  assign win_last  = (k == k_w'(half_len - 1));
  assign cand_last = (cand == addr_w'(burst_len - 1));
  assign in_metric = (phase == sync_state_pkg::METRIC);

  // port a belongs to the cp remover during COPY
  assign rd_addr_a = (phase == sync_state_pkg::COPY) ? copy_addr : cand + addr_w'(k);
  assign rd_addr_b = cand + addr_w'(k) + addr_w'(half_len);

  assign busy  = (phase != sync_state_pkg::CAPTURE);
  assign ready = (phase == sync_state_pkg::READY);

  ////////////////////////////////////////
  // phase FSM and counters
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase      <= sync_state_pkg::CAPTURE;
      cap_cnt    <= '0;
      cand       <= '0;
      k          <= '0;
      drain_cnt  <= 1'b0;
      clear      <= 1'b0;
      copy_start <= 1'b0;
    end else if (restart) begin
      phase      <= sync_state_pkg::CAPTURE;
      cap_cnt    <= '0;
      cand       <= '0;
      k          <= '0;
      drain_cnt  <= 1'b0;
      clear      <= 1'b1;  // peak detector starts over as well
      copy_start <= 1'b0;
    end else begin
      clear      <= 1'b0;
      copy_start <= 1'b0;
      case (phase)
        sync_state_pkg::CAPTURE: begin
          if (wr_en) begin
            cap_cnt <= cap_cnt + 1'b1;
          end
          if (cap_last) begin
            phase <= sync_state_pkg::METRIC;
            clear <= 1'b1;
          end
        end
        sync_state_pkg::METRIC: begin
          if (win_last) begin
            k <= '0;
            if (cand_last) begin
              phase <= sync_state_pkg::DRAIN;
            end else begin
              cand <= cand + 1'b1;
            end
          end else begin
            k <= k + 1'b1;
          end
        end
        sync_state_pkg::DRAIN: begin
          drain_cnt <= ~drain_cnt;  // two cycles for the pipeline tail
          if (drain_cnt) begin
            phase      <= sync_state_pkg::COPY;
            copy_start <= 1'b1;
          end
        end
        sync_state_pkg::COPY: begin
          if (copy_done) begin
            phase <= sync_state_pkg::READY;
          end
        end
        sync_state_pkg::READY: begin
          phase <= sync_state_pkg::READY;  // held until restart
        end
        default: phase <= sync_state_pkg::CAPTURE;
      endcase
    end
  end

  // pair flags lag the addresses by one cycle, matching the read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pair_valid <= 1'b0;
      pair_first <= 1'b0;
      pair_last  <= 1'b0;
    end else if (restart) begin
      pair_valid <= 1'b0;
      pair_first <= 1'b0;
      pair_last  <= 1'b0;
    end else begin
      pair_valid <= in_metric;
      pair_first <= in_metric && (k == '0);
      pair_last  <= in_metric && win_last;
    end
  end

endmodule

//--- logic/sync_state_pkg.sv
package sync_state_pkg;

  // controller phases, in the order a burst walks through them
  typedef enum logic [2:0] {
    CAPTURE = 3'd0,  // filling the sample buffer
    METRIC  = 3'd1,  // issuing sample pairs to the metric pipeline
    DRAIN   = 3'd2,  // letting the last metric reach the peak detector
    COPY    = 3'd3,  // cp removal into the symbol buffer
    READY   = 3'd4   // symbol buffer can be read out
  } phase_e;

endpackage

//--- logic/timing_metric.sv
`timescale 1ns/1ps

module timing_metric (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ofdm_frame_pkg::sample_t sample_a,
  input  ofdm_frame_pkg::sample_t sample_b,
  input  logic                    pair_valid,
  input  logic                    pair_first,
  input  logic                    pair_last,
  output ofdm_frame_pkg::corr_t   p,
  output ofdm_frame_pkg::energy_t r,
  output logic                    metric_valid
);

  logic signed [15:0] prod_ab;  // r[d+k] * r[d+k+L]
  logic        [15:0] prod_bb;  // r[d+k+L] squared, at most 16384
  logic               valid_q;
  logic               first_q;
  logic               last_q;

  ////////////////////////////////////////
  // stage 1, products
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    prod_ab <= sample_a * sample_b;
    prod_bb <= sample_b * sample_b;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= pair_valid;
      first_q <= pair_valid && pair_first;
      last_q  <= pair_valid && pair_last;
    end
  end

  ////////////////////////////////////////
  // stage 2, window sums
  ////////////////////////////////////////

  // the first product of a window overwrites the previous sums,
  // which are still on p and r during the metric_valid cycle
  always_ff @(posedge clk) begin
    if (valid_q) begin
      if (first_q) begin
        p <= prod_ab;
        r <= prod_bb;
      end else begin
        p <= p + prod_ab;
        r <= r + prod_bb;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      metric_valid <= 1'b0;
    end else begin
      metric_valid <= last_q;  // sums complete for one candidate
    end
  end

endmodule

//--- ofdm_time_sync.f
logic/ofdm_frame_pkg.sv
logic/sync_state_pkg.sv
logic/sample_buffer.sv
logic/timing_metric.sv
logic/peak_detector.sv
logic/cp_remover.sv
logic/symbol_buffer.sv
logic/sync_ctrl.sv
logic/ofdm_time_sync.sv
testbench/tb_ofdm_time_sync.sv

//--- testbench/sync_trace.txt
# test <name> <expected peak index, decimal>, then 120 samples
# samples are 8-bit two's complement hex, 16 per line, sample 0 first
test clean_preamble 9
00 00 00 00 00 00 00 00 00 30 d8 45 f1 22 c0 3b
0e 30 d8 45 f1 22 c0 3b 0e 00 00 00 00 00 00 00
00 5a a3 17 e9 71 04 c6 00 00 00 00 00 00 00 00
2b 96 61 fd 0c b7 48 e2 00 00 00 00 00 00 00 00
7b 35 8e d1 19 a6 53 ec 00 00 00 00 00 00 00 00
0f c2 6d 3e 91 28 f6 47 00 00 00 00 00 00 00 00
b4 1d 83 5c e0 72 a9 06 00 00 00 00 00 00 00 00
3d 9e 64 c1 27 f8 8b 50
test noisy_offset 37
11 ef 08 f5 1c e3 06 fa 00 00 00 00 00 00 00 00
f2 0d e8 14 fb 09 ee 17 00 00 00 00 00 00 00 00
00 00 00 00 00 9c 27 e5 51 f8 3a c9 12 9c 27 e5
51 f8 3a c9 12 00 00 00 00 00 00 00 00 00 00 00
0b f7 15 ea 03 fd 1a e6 00 00 00 00 00 00 00 00
f9 12 ed 07 1e e1 0a f4 00 00 00 00 00 00 00 00
13 ec 05 fb 18 e9 0c f1 00 00 00 00 00 00 00 00
fe 16 e4 0e f3 1b 02 e7

//--- testbench/tb_ofdm_time_sync.sv
`timescale 1ns/1ps

module tb_ofdm_time_sync;

  localparam int fft_len = ofdm_frame_pkg::FFT_LEN_DEF;
  localparam int cp_len  = ofdm_frame_pkg::CP_LEN_DEF;
  localparam int n_sym   = ofdm_frame_pkg::N_SYM_DEF;
  localparam int sym_len = fft_len + cp_len;
  localparam int cap_len = 2 * n_sym * sym_len;  // two bursts per capture
  localparam int n_out   = fft_len * n_sym;      // symbol bodies kept
  localparam int addr_w  = $clog2(cap_len);
  localparam int ptr_w   = $clog2(n_out);
  localparam int n_tests = 2;
  localparam int latency = 535;                  // last sample to ready
  localparam int timeout_cycles = n_tests * (cap_len + latency + n_out) + 200;
  localparam trace_path = "testbench/sync_trace.txt";

  logic                    clk;
  logic                    rst_n;
  logic                    restart;
  logic                    wren;
  ofdm_frame_pkg::sample_t din;
  ofdm_frame_pkg::sample_t dout;
  logic [ptr_w-1:0]        read_ptr;
  logic                    busy;
  logic                    ready;
  logic [addr_w-1:0]       peak_index;

  logic [7:0]      samples [n_tests * cap_len];  // trace copy of every capture
  int              peak_exp [n_tests];
  logic [8*32-1:0] test_name [n_tests];
  int              err_cnt = 0;
  int              check_cnt = 0;
  int              cycle_cnt;
  integer          seed;

  ofdm_time_sync #(.fft_len(fft_len), .cp_len(cp_len), .n_sym(n_sym)) DUT (
    .clk(clk),
    .rst_n(rst_n),
    .restart(restart),
    .din(din),
    .wren(wren),
    .read_ptr(read_ptr),
    .dout(dout),
    .busy(busy),
    .ready(ready),
    .peak_index(peak_index)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic step_clock;
    @(posedge clk);
    #1;  // inputs change away from the edge
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("error %0s: expected 0x%0h, actual 0x%0h", what, expected, actual);
    end
  endtask

  task automatic finish_run;
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic load_trace;
    integer          fd;
    integer          rc;
    integer          pk;
    int              t;
    int              i;
    logic [8*32-1:0] tok;
    logic [8*256-1:0] rest;
    logic [7:0]      smp;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      $display("could not open the trace file %0s", trace_path);
      err_cnt++;
    end else begin
      t  = 0;
      rc = $fscanf(fd, "%s", tok);
      while (rc == 1) begin
        if (tok == "#") begin
          rc = $fgets(rest, fd);  // skip the comment line
        end else if (tok == "test" && t < n_tests) begin
          rc = $fscanf(fd, "%s %d", test_name[t], pk);
          peak_exp[t] = pk;
          for (i = 0; i < cap_len; i++) begin
            rc = $fscanf(fd, "%h", smp);
            if (rc != 1) begin
              $display("trace ends early inside test %0d", t);
              err_cnt++;
            end
            samples[t * cap_len + i] = smp;
          end
          t++;
        end else begin
          $display("unexpected word in the trace file");
          err_cnt++;
        end
        rc = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
      if (t != n_tests) begin
        $display("trace holds %0d tests instead of %0d", t, n_tests);
        err_cnt++;
      end
    end
  endtask

  ////////////////////////////////////////
  // test steps
  ////////////////////////////////////////

  task automatic capture_burst(input int t, input string tag);
    int idx;
    idx = 0;
    while (idx < cap_len) begin
      if (($random(seed) & 3) == 0) begin
        wren = 1'b0;  // idle gap
      end else begin
        if (idx == cap_len - 1) begin
          check_value($sformatf("%0s busy before last sample", tag), 0, busy);
        end
        din  = samples[t * cap_len + idx];
        wren = 1'b1;
        idx++;
      end
      step_clock();
    end
    wren = 1'b0;
    check_value($sformatf("%0s busy after capture", tag), 1, busy);
    // late sample that must leave the capture untouched
    repeat (3) step_clock();
    din  = 8'h7f;
    wren = 1'b1;
    step_clock();
    wren = 1'b0;
    din  = '0;
  endtask

  task automatic read_symbols(input int t, input string tag);
    int i;
    int src;
    for (i = 0; i < n_out; i++) begin
      read_ptr = ptr_w'(i);
      step_clock();
      // body k of symbol s sits at peak + s*(fft_len+cp_len) + k
      src = t * cap_len + peak_exp[t] + (i / fft_len) * sym_len + (i % fft_len);
      check_value($sformatf("%0s dout[%0d]", tag, i), samples[src], $unsigned(dout));
    end
    read_ptr = '0;
  endtask

  task automatic run_test(input int t);
    string tag;
    tag = $sformatf("%0s", test_name[t]);
    capture_burst(t, tag);
    while (ready !== 1'b1) begin
      step_clock();
    end
    check_value($sformatf("%0s peak_index", tag), peak_exp[t], peak_index);
    read_symbols(t, tag);
  endtask

  ////////////////////////////////////////
  // main sequence and timeout
  ////////////////////////////////////////

  initial begin
    rst_n    = 1'b0;
    restart  = 1'b0;
    din      = '0;
    wren     = 1'b0;
    read_ptr = '0;
    seed     = 32'h47ae_aef8;
    load_trace();
    if (err_cnt != 0) begin
      finish_run();  // no usable trace
    end else begin
      repeat (2) @(posedge clk);  // reset held two cycles
      #1;
      rst_n = 1'b1;
      check_value("reset busy", 0, busy);
      check_value("reset ready", 0, ready);
      run_test(0);
      restart = 1'b1;
      step_clock();
      restart = 1'b0;
      check_value("restart ready", 0, ready);
      check_value("restart busy", 0, busy);  // back in capture
      run_test(1);
      finish_run();
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without reaching the end", timeout_cycles);
    err_cnt++;
    finish_run();
  end

endmodule
